// File: Makefile
VERILATOR  = verilator
FILELIST   = vertex_proj.f
TB_TOP     = tb_vertex_proj
RTL_TOP    = vertex_proj_top
OBJ_DIR    = obj_dir
LINT_FLAGS = --lint-only -Wall --timing
SIM_FLAGS  = --binary --timing --assert -Wno-fatal

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TB_TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TB_TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: rtl/gfx_pkg.sv
package gfx_pkg;

    localparam int Q_FRAC  = 16;
    localparam int Q_WIDTH = 32;

    typedef logic signed [Q_WIDTH-1:0]   q16_16_t;
    typedef logic signed [Q_WIDTH/2-1:0] pixel_t;
    typedef logic [23:0]                 color_t;

    typedef struct packed {
        q16_16_t x;
        q16_16_t y;
        q16_16_t z;
    } vec3_t;

    typedef struct packed {
        vec3_t  pos;
        color_t color;
    } vertex_t;

    typedef struct packed {
        pixel_t  sx;
        pixel_t  sy;
        q16_16_t depth;
        color_t  color;
    } screen_vertex_t;

    // AXI4-Lite register map
    localparam logic [3:0] REG_FOCAL    = 4'h0;
    localparam logic [3:0] REG_CENTER_X = 4'h4;
    localparam logic [3:0] REG_CENTER_Y = 4'h8;
    localparam logic [3:0] REG_COUNT    = 4'hC;

    localparam q16_16_t RECIP_MAX = 32'sh7FFF_FFFF;

    // Both products truncated back to q16.16
    function automatic q16_16_t project_q16_16(q16_16_t f, q16_16_t c, q16_16_t zinv);
        logic signed [2*Q_WIDTH-1:0] prod;
        q16_16_t                     fc;
        prod = f * c;
        fc   = prod[Q_WIDTH+Q_FRAC-1:Q_FRAC];
        prod = fc * zinv;
        return prod[Q_WIDTH+Q_FRAC-1:Q_FRAC];
    endfunction

endpackage

// File: rtl/proj_regs.sv
`timescale 1ns/1ps

module proj_regs import gfx_pkg::*; (
    input  logic        clk,
    input  logic        rst,

    input  logic [3:0]  awaddr,
    input  logic        awvalid,
    output logic        awready,
    input  logic [31:0] wdata,
    input  logic [3:0]  wstrb,
    input  logic        wvalid,
    output logic        wready,
    output logic [1:0]  bresp,
    output logic        bvalid,
    input  logic        bready,
    input  logic [3:0]  araddr,
    input  logic        arvalid,
    output logic        arready,
    output logic [31:0] rdata,
    output logic [1:0]  rresp,
    output logic        rvalid,
    input  logic        rready,

    input  logic        vertex_done,
    output q16_16_t     focal_length,
    output q16_16_t     center_x,
    output q16_16_t     center_y
);

    logic        aw_held;
    logic        w_held;
    logic [3:0]  aw_addr_q;
    logic [31:0] w_data_q;
    logic [3:0]  w_strb_q;
    logic        aw_seen;
    logic        w_seen;
    logic        wr_fire;
    logic [3:0]  wr_addr;
    logic [31:0] wr_data;
    logic [3:0]  wr_strb;
    logic [31:0] vertex_count;
    logic [31:0] rd_mux;
    logic        aw_taken;
    logic        w_taken;

    function automatic logic [31:0] merge_bytes(logic [31:0] old, logic [31:0] data,
                                                logic [3:0] strb);
        logic [31:0] res;
        res = old;
        for (int i = 0; i < 4; i++) begin
            if (strb[i]) begin
                res[8*i +: 8] = data[8*i +: 8];
            end
        end
        return res;
    endfunction

    assign awready = !aw_held && !bvalid;
    assign wready  = !w_held && !bvalid;
    assign arready = !rvalid;
    assign bresp   = 2'b00;
    assign rresp   = 2'b00;

    // Address and data may arrive in either order
    assign aw_seen = aw_held || (awvalid && awready);
    assign w_seen  = w_held || (wvalid && wready);
    assign wr_fire = aw_seen && w_seen;
    assign wr_addr = aw_held ? aw_addr_q : awaddr;
    assign wr_data = w_held ? w_data_q : wdata;
    assign wr_strb = w_held ? w_strb_q : wstrb;

    always_comb begin
        case (araddr)
            REG_FOCAL:    rd_mux = focal_length;
            REG_CENTER_X: rd_mux = center_x;
            REG_CENTER_Y: rd_mux = center_y;
            REG_COUNT:    rd_mux = vertex_count;
            default:      rd_mux = '0;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            aw_held      <= 1'b0;
            w_held       <= 1'b0;
            bvalid       <= 1'b0;
            rvalid       <= 1'b0;
            focal_length <= q16_16_t'(1 << Q_FRAC);
            center_x     <= '0;
            center_y     <= '0;
            vertex_count <= '0;
        end else begin
            if (wr_fire) begin
                aw_held <= 1'b0;
                w_held  <= 1'b0;
                bvalid  <= 1'b1;
                case (wr_addr)
                    REG_FOCAL:    focal_length <= merge_bytes(focal_length, wr_data, wr_strb);
                    REG_CENTER_X: center_x <= merge_bytes(center_x, wr_data, wr_strb);
                    REG_CENTER_Y: center_y <= merge_bytes(center_y, wr_data, wr_strb);
                    default: ;
                endcase
            end else begin
                aw_held <= aw_seen;
                w_held  <= w_seen;
                if (bready) begin
                    bvalid <= 1'b0;
                end
            end
            if (arvalid && arready) begin
                rvalid <= 1'b1;
            end else if (rready) begin
                rvalid <= 1'b0;
            end
            // Wraps at 2^32
            if (vertex_done) begin
                vertex_count <= vertex_count + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (awvalid && awready) begin
            aw_addr_q <= awaddr;
        end
        if (wvalid && wready) begin
            w_data_q <= wdata;
            w_strb_q <= wstrb;
        end
        if (arvalid && arready) begin
            rdata <= rd_mux;
        end
    end

    // Port handshakes since the last write response
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            aw_taken <= 1'b0;
            w_taken  <= 1'b0;
        end else if (bvalid) begin
            aw_taken <= 1'b0;
            w_taken  <= 1'b0;
        end else begin
            if (awvalid && awready) begin
                aw_taken <= 1'b1;
            end
            if (wvalid && wready) begin
                w_taken <= 1'b1;
            end
        end
    end

    assert property (@(posedge clk) disable iff (rst) $rose(bvalid) |-> aw_taken && w_taken)
        else $error("proj_regs: write response without address and data");

endmodule

// File: rtl/recip_divider.sv
`timescale 1ns/1ps

module recip_divider import gfx_pkg::*; #(
    parameter int WIDTH = Q_WIDTH
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             start,
    input  logic [WIDTH-1:0] a,
    input  logic [WIDTH-1:0] b,
    output logic             busy,
    output logic             done,
    output logic [WIDTH-1:0] quotient
);

    typedef enum logic [1:0] {
        IDLE,
        RUN,
        FINISH
    } div_state_t;

    div_state_t               state;
    logic [$clog2(WIDTH)-1:0] iter;
    logic [WIDTH:0]           rem;
    logic [WIDTH:0]           trial;
    logic [WIDTH-1:0]         dvd;
    logic [WIDTH-1:0]         divisor;
    logic [WIDTH-1:0]         quo;
    logic                     ovf;

    assign busy  = (state != IDLE);
    // Partial remainder with the next dividend bit shifted in
    assign trial = {rem[WIDTH-1:0], dvd[WIDTH-1]};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= IDLE;
            iter  <= '0;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                IDLE: begin
                    iter <= '0;
                    if (start) begin
                        state <= RUN;
                    end
                end
                RUN: begin
                    iter <= iter + 1'b1;
                    if (iter == ($clog2(WIDTH))'(WIDTH - 1)) begin
                        state <= FINISH;
                    end
                end
                FINISH: begin
                    done  <= 1'b1;
                    state <= IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (state)
            IDLE: begin
                if (start) begin
                    // Top Q_FRAC bits of a<<Q_FRAC sit above the quotient range
                    rem     <= {1'b0, a >> (WIDTH - Q_FRAC)};
                    dvd     <= a << Q_FRAC;
                    divisor <= b;
                    quo     <= '0;
                    ovf     <= (a >> (WIDTH - Q_FRAC)) >= b;
                end
            end
            RUN: begin
                dvd <= dvd << 1;
                if (trial >= {1'b0, divisor}) begin
                    rem <= trial - {1'b0, divisor};
                    quo <= {quo[WIDTH-2:0], 1'b1};
                end else begin
                    rem <= trial;
                    quo <= {quo[WIDTH-2:0], 1'b0};
                end
            end
            FINISH: quotient <= ovf ? WIDTH'(RECIP_MAX) : quo;
            default: ;
        endcase
    end

    // Caller must wait for done before the next start
    assert property (@(posedge clk) disable iff (rst) start |-> !busy)
        else $error("recip_divider: start raised while busy");

endmodule

// File: rtl/vertex_proj_top.sv
`timescale 1ns/1ps

module vertex_proj_top import gfx_pkg::*; (
    input  logic           clk,
    input  logic           rst,

    input  logic [3:0]     awaddr,
    input  logic           awvalid,
    output logic           awready,
    input  logic [31:0]    wdata,
    input  logic [3:0]     wstrb,
    input  logic           wvalid,
    output logic           wready,
    output logic [1:0]     bresp,
    output logic           bvalid,
    input  logic           bready,
    input  logic [3:0]     araddr,
    input  logic           arvalid,
    output logic           arready,
    output logic [31:0]    rdata,
    output logic [1:0]     rresp,
    output logic           rvalid,
    input  logic           rready,

    input  vertex_t        in_vertex,
    input  logic           in_valid,
    output logic           in_ready,

    output screen_vertex_t out_vertex,
    output logic           out_valid,
    input  logic           out_ready,

    output logic           busy
);

    q16_16_t focal_length;
    q16_16_t center_x;
    q16_16_t center_y;
    vertex_t proj_vertex;
    logic    proj_valid;
    logic    proj_ready;
    logic    vertex_done;

    // Counted once per emitted screen vertex
    assign vertex_done = out_valid && out_ready;

    proj_regs proj_regs_i (
        .clk          (clk),
        .rst          (rst),
        .awaddr       (awaddr),
        .awvalid      (awvalid),
        .awready      (awready),
        .wdata        (wdata),
        .wstrb        (wstrb),
        .wvalid       (wvalid),
        .wready       (wready),
        .bresp        (bresp),
        .bvalid       (bvalid),
        .bready       (bready),
        .araddr       (araddr),
        .arvalid      (arvalid),
        .arready      (arready),
        .rdata        (rdata),
        .rresp        (rresp),
        .rvalid       (rvalid),
        .rready       (rready),
        .vertex_done  (vertex_done),
        .focal_length (focal_length),
        .center_x     (center_x),
        .center_y     (center_y)
    );

    vertex_projector vertex_projector_i (
        .clk          (clk),
        .rst          (rst),
        .in_vertex    (in_vertex),
        .in_valid     (in_valid),
        .in_ready     (in_ready),
        .focal_length (focal_length),
        .proj_vertex  (proj_vertex),
        .proj_valid   (proj_valid),
        .proj_ready   (proj_ready),
        .busy         (busy)
    );

    viewport_mapper viewport_mapper_i (
        .clk         (clk),
        .rst         (rst),
        .proj_vertex (proj_vertex),
        .proj_valid  (proj_valid),
        .proj_ready  (proj_ready),
        .center_x    (center_x),
        .center_y    (center_y),
        .out_vertex  (out_vertex),
        .out_valid   (out_valid),
        .out_ready   (out_ready)
    );

endmodule

// File: rtl/vertex_projector.sv
`timescale 1ns/1ps

module vertex_projector import gfx_pkg::*; (
    input  logic    clk,
    input  logic    rst,

    input  vertex_t in_vertex,
    input  logic    in_valid,
    output logic    in_ready,

    input  q16_16_t focal_length,

    output vertex_t proj_vertex,
    output logic    proj_valid,
    input  logic    proj_ready,
    output logic    busy
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_LOAD,
        S_DIV,
        S_OUT
    } proj_state_t;

    proj_state_t        state;
    vertex_t            v_reg;
    logic [Q_WIDTH-1:0] z_abs;
    logic [Q_WIDTH-1:0] div_b;
    logic               div_start;
    logic               div_done;
    logic [Q_WIDTH-1:0] div_quotient;
    q16_16_t            px;
    q16_16_t            py;

    // One vertex at a time
    assign busy     = (state != S_IDLE);
    assign in_ready = (state == S_IDLE);

    // Raw-bit magnitude, 0x80000000 stays as 2^31
    assign z_abs = v_reg.pos.z[Q_WIDTH-1] ? -v_reg.pos.z : v_reg.pos.z;

    recip_divider #(
        .WIDTH (Q_WIDTH)
    ) recip_divider_i (
        .clk      (clk),
        .rst      (rst),
        .start    (div_start),
        .a        (Q_WIDTH'(1 << Q_FRAC)),
        .b        (div_b),
        .busy     (),
        .done     (div_done),
        .quotient (div_quotient)
    );

    always_comb begin
        px = project_q16_16(focal_length, v_reg.pos.x, q16_16_t'(div_quotient));
        py = project_q16_16(focal_length, v_reg.pos.y, q16_16_t'(div_quotient));
        // Behind the camera
        if (v_reg.pos.z[Q_WIDTH-1]) begin
            px = -px;
            py = -py;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= S_IDLE;
            div_start  <= 1'b0;
            proj_valid <= 1'b0;
        end else begin
            div_start <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (in_valid) begin
                        state <= S_LOAD;
                    end
                end
                S_LOAD: begin
                    div_start <= 1'b1;
                    state     <= S_DIV;
                end
                S_DIV: begin
                    if (div_done) begin
                        proj_valid <= 1'b1;
                        state      <= S_OUT;
                    end
                end
                S_OUT: begin
                    if (proj_ready) begin
                        proj_valid <= 1'b0;
                        state      <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            v_reg <= in_vertex;
        end
        if (state == S_LOAD) begin
            div_b <= (z_abs == '0) ? Q_WIDTH'(1) : z_abs;
        end
        if (state == S_DIV && div_done) begin
            proj_vertex.pos.x <= px;
            proj_vertex.pos.y <= py;
            proj_vertex.pos.z <= v_reg.pos.z;
            proj_vertex.color <= v_reg.color;
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        proj_valid && !proj_ready |=> proj_valid && $stable(proj_vertex))
        else $error("vertex_projector: output changed under back-pressure");

endmodule

// File: rtl/viewport_mapper.sv
`timescale 1ns/1ps

module viewport_mapper import gfx_pkg::*; (
    input  logic           clk,
    input  logic           rst,

    input  vertex_t        proj_vertex,
    input  logic           proj_valid,
    output logic           proj_ready,

    input  q16_16_t        center_x,
    input  q16_16_t        center_y,

    output screen_vertex_t out_vertex,
    output logic           out_valid,
    input  logic           out_ready
);

    q16_16_t        scr_x;
    q16_16_t        scr_y;
    screen_vertex_t mapped;

    // Empty, or draining this cycle
    assign proj_ready = !out_valid || out_ready;

    // Screen y grows downward
    assign scr_x = center_x + proj_vertex.pos.x;
    assign scr_y = center_y - proj_vertex.pos.y;

    always_comb begin
        mapped.sx    = scr_x[Q_WIDTH-1:Q_FRAC];
        mapped.sy    = scr_y[Q_WIDTH-1:Q_FRAC];
        mapped.depth = proj_vertex.pos.z;
        mapped.color = proj_vertex.color;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else if (proj_valid && proj_ready) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (proj_valid && proj_ready) begin
            out_vertex <= mapped;
        end
    end

endmodule

// File: sim/proj_vectors.txt
# W offset data | R offset expected | S stall_mode (0 = out_ready high, 1 = random stalls)
# V name x y z colour sx sy depth colour, all hex, q16.16 positions, 16-bit pixels
R C 00000000
W C 12345678
R C 00000000
R 0 00010000
W 0 00400000
W 4 00A00000
W 8 00780000
R 0 00400000
R 4 00A00000
R 8 00780000
S 0
V pos_z1 00010000 00008000 00010000 FF0000 00E0 0058 00010000 FF0000
V pos_z2 FFFE8000 00014000 00020000 00FF00 0070 0050 00020000 00FF00
V pos_z4 00020000 FFFE0000 00040000 0000FF 00C0 0098 00040000 0000FF
V pos_z3_frac 00010000 00000000 00030000 A0B0C0 00B5 0078 00030000 A0B0C0
V neg_z2 00010000 00010000 FFFE0000 808080 0080 0098 FFFE0000 808080
V neg_z1 00008000 FFFFC000 FFFF0000 123456 0080 0068 FFFF0000 123456
V neg_z3_frac 00010000 00000000 FFFD0000 654321 008A 0078 FFFD0000 654321
V zero_z 00010000 00008000 00000000 FFFFFF 009F 0078 00000000 FFFFFF
S 1
V stall_0 00000000 00000000 00010000 010203 00A0 0078 00010000 010203
V stall_1 00010000 00010000 00010000 040506 00E0 0038 00010000 040506
V stall_2 FFFF0000 FFFF0000 00010000 070809 0060 00B8 00010000 070809
V stall_3 00020000 00000000 00020000 0A0B0C 00E0 0078 00020000 0A0B0C
V stall_4 00000000 00020000 00040000 0D0E0F 00A0 0058 00040000 0D0E0F
V stall_5 FFFE0000 00010000 FFFF0000 101112 0120 00B8 FFFF0000 101112
V stall_6 00008000 FFFF8000 00020000 131415 00B0 0088 00020000 131415
V stall_7 00010000 00000000 00030000 161718 00B5 0078 00030000 161718
S 0
R C 00000010

// File: sim/tb_vertex_proj.sv
`timescale 1ns/1ps

module tb_vertex_proj
    import gfx_pkg::*;
();

    localparam int TIMEOUT_CYCLES = 5000;
    localparam int LATENCY        = 37;

    logic           clk;
    logic           rst;
    logic [3:0]     awaddr;
    logic           awvalid;
    logic           awready;
    logic [31:0]    wdata;
    logic [3:0]     wstrb;
    logic           wvalid;
    logic           wready;
    logic [1:0]     bresp;
    logic           bvalid;
    logic           bready;
    logic [3:0]     araddr;
    logic           arvalid;
    logic           arready;
    logic [31:0]    rdata;
    logic [1:0]     rresp;
    logic           rvalid;
    logic           rready;
    vertex_t        in_vertex;
    logic           in_valid;
    logic           in_ready;
    screen_vertex_t out_vertex;
    logic           out_valid;
    logic           out_ready;
    logic           busy;

    screen_vertex_t exp_q[$];
    string          name_q[$];
    int             rx_count;
    logic           stall_on;
    logic [31:0]    rnd;
    int             stall_left;

    vertex_proj_top vertex_proj_top_i (.*);

    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;
        end
    end

    task automatic stop_with_failure();
        $display("Test failed");
        $fatal(1);
    endtask

    function automatic logic [31:0] xorshift32(logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic string format_screen_vertex(screen_vertex_t v);
        return $sformatf("sx=%04h sy=%04h depth=%08h color=%06h",
                         v.sx, v.sy, v.depth, v.color);
    endfunction

    task automatic check_reg(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            $display("MISMATCH %s expected %08h actual %08h", name, exp, act);
            stop_with_failure();
        end
    endtask

    task automatic check_pixel(input string name, input pixel_t exp, input pixel_t act);
        if (act !== exp) begin
            $display("MISMATCH %s expected %0d actual %0d", name, exp, act);
            stop_with_failure();
        end
    endtask

    task automatic check_screen_vertex(input string name, input screen_vertex_t exp,
                                       input screen_vertex_t act);
        if (act !== exp) begin
            $display("MISMATCH %s expected %s actual %s", name,
                     format_screen_vertex(exp), format_screen_vertex(act));
            stop_with_failure();
        end
    endtask

    task automatic axi_write(input logic [3:0] addr, input logic [31:0] data);
        int   tries;
        logic aw_go;
        logic w_go;
        logic resp_seen;
        @(posedge clk);
        #1;
        awaddr  = addr;
        awvalid = 1'b1;
        wdata   = data;
        wstrb   = 4'hF;
        wvalid  = 1'b1;
        bready  = 1'b1;
        tries   = 0;
        while (awvalid || wvalid) begin
            @(negedge clk);
            aw_go = awvalid && awready;
            w_go  = wvalid && wready;
            @(posedge clk);
            #1;
            if (aw_go) awvalid = 1'b0;
            if (w_go) wvalid = 1'b0;
            tries++;
            if (tries > TIMEOUT_CYCLES) begin
                $display("Timeout: AXI write address or data was never accepted");
                stop_with_failure();
            end
        end
        resp_seen = 1'b0;
        tries     = 0;
        while (!resp_seen) begin
            @(negedge clk);
            tries++;
            if (bvalid) begin
                resp_seen = 1'b1;
            end else if (tries > TIMEOUT_CYCLES) begin
                $display("Timeout: no AXI write response arrived");
                stop_with_failure();
            end
        end
        check_reg("write_resp", 32'd0, {30'd0, bresp});
        @(posedge clk);
        #1;
        bready = 1'b0;
    endtask

    task automatic axi_read(input logic [3:0] addr, output logic [31:0] data);
        int   tries;
        logic addr_done;
        logic data_seen;
        @(posedge clk);
        #1;
        araddr    = addr;
        arvalid   = 1'b1;
        rready    = 1'b1;
        addr_done = 1'b0;
        tries     = 0;
        while (!addr_done) begin
            @(negedge clk);
            addr_done = arready;
            @(posedge clk);
            #1;
            tries++;
            if (addr_done) begin
                arvalid = 1'b0;
            end else if (tries > TIMEOUT_CYCLES) begin
                $display("Timeout: AXI read address was never accepted");
                stop_with_failure();
            end
        end
        data_seen = 1'b0;
        tries     = 0;
        while (!data_seen) begin
            @(negedge clk);
            tries++;
            if (rvalid) begin
                data_seen = 1'b1;
            end else if (tries > TIMEOUT_CYCLES) begin
                $display("Timeout: no AXI read data arrived");
                stop_with_failure();
            end
        end
        data = rdata;
        check_reg("read_resp", 32'd0, {30'd0, rresp});
        @(posedge clk);
        #1;
        rready = 1'b0;
    endtask

    task automatic wait_for_drain();
        int tries;
        tries = 0;
        while (exp_q.size() != 0) begin
            @(negedge clk);
            tries++;
            if (tries > TIMEOUT_CYCLES) begin
                $display("Timeout: expected vertices never left the DUT");
                stop_with_failure();
            end
        end
    endtask

    // Rising edges after the accept edge until out_valid is up
    task automatic measure_latency(input string name);
        int   lat;
        logic seen;
        lat  = 0;
        seen = 1'b0;
        while (!seen) begin
            @(negedge clk);
            if (out_valid) begin
                seen = 1'b1;
            end else begin
                lat++;
                if (lat > TIMEOUT_CYCLES) begin
                    $display("Timeout: out_valid never rose for vertex %s", name);
                    stop_with_failure();
                end
            end
        end
        check_reg({name, "_latency"}, LATENCY, lat);
    endtask

    task automatic send_vertex(input string name, input vertex_t v, input screen_vertex_t e);
        int   tries;
        logic accepted;
        exp_q.push_back(e);
        name_q.push_back(name);
        @(posedge clk);
        #1;
        in_vertex = v;
        in_valid  = 1'b1;
        accepted  = 1'b0;
        tries     = 0;
        while (!accepted) begin
            @(negedge clk);
            tries++;
            if (in_ready) begin
                accepted = 1'b1;
            end else if (tries > TIMEOUT_CYCLES) begin
                $display("Timeout: vertex %s was never accepted", name);
                stop_with_failure();
            end
        end
        @(posedge clk);
        #1;
        in_valid = 1'b0;
        if (!stall_on) begin
            measure_latency(name);
        end
    endtask

    task automatic check_output();
        screen_vertex_t e;
        string          name;
        if (exp_q.size() == 0) begin
            $display("Output vertex appeared with none expected");
            stop_with_failure();
        end else begin
            e    = exp_q.pop_front();
            name = name_q.pop_front();
            check_pixel({name, "_sx"}, e.sx, out_vertex.sx);
            check_pixel({name, "_sy"}, e.sy, out_vertex.sy);
            check_screen_vertex(name, e, out_vertex);
            rx_count++;
        end
    endtask

    // Output sink with bursty stalls
    initial begin
        out_ready  = 1'b0;
        rnd        = 32'd37;
        stall_left = 0;
        forever begin
            @(posedge clk);
            #1;
            if (!stall_on) begin
                out_ready  = 1'b1;
                stall_left = 0;
            end else if (stall_left != 0) begin
                out_ready  = 1'b0;
                stall_left = stall_left - 1;
            end else begin
                rnd = xorshift32(rnd);
                if (rnd[2:0] == 3'd0) begin
                    stall_left = int'(rnd[10:5]);
                    out_ready  = 1'b0;
                end else begin
                    out_ready = 1'b1;
                end
            end
        end
    end

    initial begin
        forever begin
            @(negedge clk);
            if (!rst) begin
                if (busy && in_ready) begin
                    $display("in_ready was high while the projector was busy");
                    stop_with_failure();
                end
                if (out_valid && out_ready) begin
                    check_output();
                end
            end
        end
    end

    initial begin
        int               fd;
        int               n;
        int               code;
        int               mode;
        logic [8*32-1:0]  kind;
        logic [8*32-1:0]  name_word;
        logic [8*256-1:0] line;
        logic [3:0]       off;
        logic [31:0]      data;
        logic [31:0]      got;
        q16_16_t          vx;
        q16_16_t          vy;
        q16_16_t          vz;
        q16_16_t          edepth;
        color_t           vcol;
        color_t           ecol;
        pixel_t           esx;
        pixel_t           esy;
        vertex_t          v;
        screen_vertex_t   e;
        rst       = 1'b1;
        awaddr    = '0;
        awvalid   = 1'b0;
        wdata     = '0;
        wstrb     = '0;
        wvalid    = 1'b0;
        bready    = 1'b0;
        araddr    = '0;
        arvalid   = 1'b0;
        rready    = 1'b0;
        in_vertex = '0;
        in_valid  = 1'b0;
        stall_on  = 1'b0;
        rx_count  = 0;
        fd = $fopen("sim/proj_vectors.txt", "r");
        if (fd == 0) begin
            $display("Could not open the vector file sim/proj_vectors.txt");
            stop_with_failure();
        end
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;

        n = $fscanf(fd, "%s", kind);
        while (n == 1) begin
            if (kind == "#") begin
                code = $fgets(line, fd);
            end else if (kind == "W") begin
                code = $fscanf(fd, "%h %h", off, data);
                axi_write(off, data);
            end else if (kind == "R") begin
                code = $fscanf(fd, "%h %h", off, data);
                wait_for_drain();
                axi_read(off, got);
                check_reg($sformatf("reg_%0h", off), data, got);
                if (off == REG_COUNT) begin
                    check_reg("count_vs_received", rx_count, got);
                end
            end else if (kind == "S") begin
                code = $fscanf(fd, "%d", mode);
                wait_for_drain();
                stall_on = (mode != 0);
            end else if (kind == "V") begin
                code = $fscanf(fd, "%s %h %h %h %h %h %h %h %h", name_word, vx, vy, vz, vcol,
                               esx, esy, edepth, ecol);
                if (code != 9) begin
                    $display("Malformed vertex record in the vector file");
                    stop_with_failure();
                end
                v.pos.x  = vx;
                v.pos.y  = vy;
                v.pos.z  = vz;
                v.color  = vcol;
                e.sx     = esx;
                e.sy     = esy;
                e.depth  = edepth;
                e.color  = ecol;
                send_vertex($sformatf("%0s", name_word), v, e);
            end else begin
                $display("Unknown record kind %0s in the vector file", kind);
                stop_with_failure();
            end
            n = $fscanf(fd, "%s", kind);
        end

        wait_for_drain();
        $fclose(fd);
        $display("Test completed successfully");
        $finish;
    end

endmodule

// File: vertex_proj.f
rtl/gfx_pkg.sv
rtl/recip_divider.sv
rtl/vertex_projector.sv
rtl/viewport_mapper.sv
rtl/proj_regs.sv
rtl/vertex_proj_top.sv
sim/tb_vertex_proj.sv
